// File: source/dcache_pkg.sv
/*
 * dcache shared definitions
 * widths, load bundle types, load-control microcode word and APB register map
 */
package dcache_pkg;

    // sizes fixed by the memory map
    localparam int NUM_LINES = 4;
    localparam int MEM_WORDS = 16;

    typedef logic [31:0] addr_t;
    typedef logic [63:0] data_t;
    typedef logic [1:0]  cache_index_t;
    typedef logic [1:0]  cache_tag_t;
    typedef logic [3:0]  mem_index_t;
    typedef logic [3:0]  miss_lat_t;
    typedef logic [15:0] count_t;

    // bundle from the previous stage
    typedef struct packed {
        addr_t op0_addr;
        logic  op0_valid;
        addr_t op1_addr;
        logic  op1_valid;
    } load_op_t;

    typedef struct packed {
        data_t op0_data;
        data_t op1_data;
    } load_result_t;

    typedef enum logic [2:0] {
        LD_IDLE,
        LD_REQ0,
        LD_WAIT0,
        LD_REQ1,
        LD_WAIT1,
        LD_DONE
    } ctrl_state_e;

    // branch condition of a control word
    typedef enum logic [1:0] {
        COND_NONE,
        COND_START,
        COND_REQ_READY,
        COND_RSP_VALID
    } cond_e;

    typedef struct packed {
        cond_e       cond;
        ctrl_state_e jump;
        logic        req_valid;
        logic        rsp_ready;
        logic        a_ready;
        logic        e_valid;
        logic        ld_op0;
        logic        ld_op1;
    } ctrl_word_t;

    // register block to cache
    typedef struct packed {
        logic      enable;
        logic      flush;
        miss_lat_t miss_lat;
    } cfg_t;

    // cache to register block, one pulse per access
    typedef struct packed {
        logic hit;
        logic miss;
    } stat_t;

    // APB byte offsets
    localparam logic [7:0] REG_CTRL     = 8'h00;
    localparam logic [7:0] REG_MISS_LAT = 8'h04;
    localparam logic [7:0] REG_HIT_CNT  = 8'h08;
    localparam logic [7:0] REG_MISS_CNT = 8'h0C;

    localparam MEM_INIT_FILE = "mem_init.hex";

endpackage

// File: source/dcache_load_ctrl.sv
/*
 * load-operand sequencer
 * fetches op0 then op1 from the data cache under a microcode ROM
 * and hands both words to the next stage
 */
`timescale 1ns/100ps

module dcache_load_ctrl (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     a_valid,
    input  dcache_pkg::load_op_t     load_op,
    output logic                     a_ready,
    output logic                     e_valid,
    input  logic                     e_ready,
    output dcache_pkg::load_result_t result,
    output logic                     req_valid,
    input  logic                     req_ready,
    output dcache_pkg::addr_t        req_addr,
    input  logic                     rsp_valid,
    output logic                     rsp_ready,
    input  dcache_pkg::data_t        rsp_data
);
    import dcache_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e jump_state;
    ctrl_state_e next_state;
    ctrl_word_t  cw;
    load_op_t    op_q;
    load_op_t    sel_op;
    logic        start;
    logic        cond_met;
    logic        advance;
    logic        accept;
    logic        rsp_take;

    // a bundle only starts the sequence if it has something to fetch
    assign start = a_valid & (load_op.op0_valid | load_op.op1_valid);

    // microcode ROM, one control word per state
    always_comb begin
        case (state_q)
            LD_IDLE:
                cw = '{cond: COND_START, jump: LD_REQ0, a_ready: 1'b1, default: 1'b0};
            LD_REQ0:
                cw = '{cond: COND_REQ_READY, jump: LD_WAIT0, req_valid: 1'b1, default: 1'b0};
            LD_WAIT0:
                cw = '{cond: COND_RSP_VALID, jump: LD_REQ1, rsp_ready: 1'b1, ld_op0: 1'b1,
                       default: 1'b0};
            LD_REQ1:
                cw = '{cond: COND_REQ_READY, jump: LD_WAIT1, req_valid: 1'b1, default: 1'b0};
            LD_WAIT1:
                cw = '{cond: COND_RSP_VALID, jump: LD_DONE, rsp_ready: 1'b1, ld_op1: 1'b1,
                       default: 1'b0};
            LD_DONE:
                cw = '{cond: COND_NONE, jump: LD_IDLE, e_valid: 1'b1, default: 1'b0};
            default:
                cw = '{cond: COND_NONE, jump: LD_IDLE, default: 1'b0};
        endcase
    end

    // handshake outputs straight from the control word
    assign a_ready   = cw.a_ready & start;
    assign req_valid = cw.req_valid;
    assign rsp_ready = cw.rsp_ready;
    assign e_valid   = cw.e_valid;

    assign accept   = a_valid & a_ready;
    assign rsp_take = rsp_valid & rsp_ready;

    // branch condition select
    always_comb begin
        case (cw.cond)
            COND_START:     cond_met = start;
            COND_REQ_READY: cond_met = req_ready;
            COND_RSP_VALID: cond_met = rsp_valid;
            default:        cond_met = 1'b1;
        endcase
    end

    // done word holds until the next stage takes the result
    assign advance = cond_met & (~cw.e_valid | e_ready);

    // in idle the bundle is being latched this cycle
    assign sel_op = cw.a_ready ? load_op : op_q;

    // skip the fetch of an operand that is not valid
    always_comb begin
        jump_state = cw.jump;
        if (jump_state == LD_REQ0 && !sel_op.op0_valid) begin
            jump_state = LD_REQ1;
        end
        if (jump_state == LD_REQ1 && !sel_op.op1_valid) begin
            jump_state = LD_DONE;
        end
        next_state = advance ? jump_state : state_q;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= LD_IDLE;
        end else begin
            state_q <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q <= load_op;
        end
    end

    // op1 address in the second half of the sequence
    assign req_addr = (state_q == LD_REQ1 || state_q == LD_WAIT1) ? op_q.op1_addr
                                                                  : op_q.op0_addr;

    // skipped operands read back as zero
    always_ff @(posedge clk) begin
        if (accept) begin
            result <= '0;
        end else if (rsp_take) begin
            if (cw.ld_op0) begin
                result.op0_data <= rsp_data;
            end
            if (cw.ld_op1) begin
                result.op1_data <= rsp_data;
            end
        end
    end

endmodule

// File: source/dcache_store.sv
/*
 * direct-mapped data cache, 4 lines of 64 bits
 * backed by a 16-word store, hit in one cycle, miss after miss_lat + 2
 */
`timescale 1ns/100ps

module dcache_store (
    input  logic              clk,
    input  logic              arst_n,
    input  dcache_pkg::cfg_t  cfg,
    output dcache_pkg::stat_t stat,
    input  logic              req_valid,
    output logic              req_ready,
    input  dcache_pkg::addr_t req_addr,
    output logic              rsp_valid,
    input  logic              rsp_ready,
    output dcache_pkg::data_t rsp_data
);
    import dcache_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_MISS,
        ST_RESP
    } store_state_e;

    store_state_e         state_q;
    logic [NUM_LINES-1:0] line_valid_q;
    cache_tag_t           tag_q [NUM_LINES];
    data_t                line_q [NUM_LINES];
    data_t                mem [MEM_WORDS];
    addr_t                addr_q;
    miss_lat_t            wait_q;
    cache_index_t         req_index;
    cache_tag_t           req_tag;
    cache_index_t         fill_index;
    cache_tag_t           fill_tag;
    mem_index_t           fill_word;
    logic                 accept;
    logic                 hit;
    logic                 fill_done;

    initial begin
        $readmemh(MEM_INIT_FILE, mem);
    end

    // address split, bits above 6 alias
    assign req_index  = req_addr[4:3];
    assign req_tag    = req_addr[6:5];
    assign fill_index = addr_q[4:3];
    assign fill_tag   = addr_q[6:5];
    assign fill_word  = addr_q[6:3];

    // one request at a time
    assign req_ready = (state_q == ST_IDLE);
    assign accept    = req_valid & req_ready;

    // disabled cache never hits
    assign hit = cfg.enable & line_valid_q[req_index] & (tag_q[req_index] == req_tag);

    assign stat.hit  = accept & hit;
    assign stat.miss = accept & ~hit;

    assign rsp_valid = (state_q == ST_RESP);

    // last wait cycle of a miss
    assign fill_done = (state_q == ST_MISS) && (wait_q == '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q      <= ST_IDLE;
            wait_q       <= '0;
            line_valid_q <= '0;
        end else begin
            if (cfg.flush) begin
                line_valid_q <= '0;
            end
            case (state_q)
                ST_IDLE: begin
                    if (accept) begin
                        state_q <= hit ? ST_RESP : ST_MISS;
                        wait_q  <= cfg.miss_lat;
                    end
                end
                ST_MISS: begin
                    if (wait_q != '0) begin
                        wait_q <= wait_q - 1'b1;
                    end else begin
                        state_q <= ST_RESP;
                        // fill lands even if a flush arrives on the same edge
                        if (cfg.enable) begin
                            line_valid_q[fill_index] <= 1'b1;
                        end
                    end
                end
                ST_RESP: begin
                    if (rsp_ready) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // request address, line data and response word
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q   <= req_addr;
            // only meaningful on a hit, a miss overwrites it at fill time
            rsp_data <= line_q[req_index];
        end
        if (fill_done) begin
            rsp_data <= mem[fill_word];
            if (cfg.enable) begin
                line_q[fill_index] <= mem[fill_word];
                tag_q[fill_index]  <= fill_tag;
            end
        end
    end

endmodule

// File: source/dcache_cfg_regs.sv
/*
 * dcache APB register block
 * enable, flush, miss penalty and saturating hit/miss counters
 */
`timescale 1ns/100ps

module dcache_cfg_regs (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [7:0]        paddr,
    input  logic [31:0]       pwdata,
    output logic [31:0]       prdata,
    output logic              pready,
    output logic              pslverr,
    output dcache_pkg::cfg_t  cfg,
    input  dcache_pkg::stat_t stat
);
    import dcache_pkg::*;

    logic      access;
    logic      wr;
    logic      map_hit;
    logic      wr_ctrl;
    logic      wr_miss_lat;
    logic      wr_hit_cnt;
    logic      wr_miss_cnt;
    logic      enable_q;
    logic      flush_q;
    miss_lat_t miss_lat_q;
    count_t    hit_cnt_q;
    count_t    miss_cnt_q;

    function automatic count_t sat_inc(count_t cnt);
        return (cnt == '1) ? cnt : cnt + 1'b1;
    endfunction

    // no wait states
    assign pready = 1'b1;

    assign access      = psel & penable;
    assign wr          = access & pwrite;
    assign wr_ctrl     = wr & (paddr == REG_CTRL);
    assign wr_miss_lat = wr & (paddr == REG_MISS_LAT);
    assign wr_hit_cnt  = wr & (paddr == REG_HIT_CNT);
    assign wr_miss_cnt = wr & (paddr == REG_MISS_CNT);

    // read mux, flush bit reads as zero
    always_comb begin
        map_hit = 1'b1;
        prdata  = '0;
        case (paddr)
            REG_CTRL:     prdata = {31'b0, enable_q};
            REG_MISS_LAT: prdata = {28'b0, miss_lat_q};
            REG_HIT_CNT:  prdata = {16'b0, hit_cnt_q};
            REG_MISS_CNT: prdata = {16'b0, miss_cnt_q};
            default:      map_hit = 1'b0;
        endcase
    end

    assign pslverr = access & ~map_hit;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            enable_q   <= 1'b0;
            flush_q    <= 1'b0;
            miss_lat_q <= '0;
        end else begin
            // flush is a single-cycle pulse
            flush_q <= wr_ctrl & pwdata[1];
            if (wr_ctrl) begin
                enable_q <= pwdata[0];
            end
            if (wr_miss_lat) begin
                miss_lat_q <= pwdata[3:0];
            end
        end
    end

    // any write clears, the clear wins over a same-cycle event
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hit_cnt_q  <= '0;
            miss_cnt_q <= '0;
        end else begin
            if (wr_hit_cnt) begin
                hit_cnt_q <= '0;
            end else if (stat.hit) begin
                hit_cnt_q <= sat_inc(hit_cnt_q);
            end
            if (wr_miss_cnt) begin
                miss_cnt_q <= '0;
            end else if (stat.miss) begin
                miss_cnt_q <= sat_inc(miss_cnt_q);
            end
        end
    end

    assign cfg = '{enable: enable_q, flush: flush_q, miss_lat: miss_lat_q};

endmodule

// File: source/dcache_top.sv
/*
 * dcache load side top level
 * load sequencer, direct-mapped cache and its APB register block
 */
`timescale 1ns/100ps

module dcache_top (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     a_valid,
    output logic                     a_ready,
    input  dcache_pkg::load_op_t     load_op,
    output logic                     e_valid,
    input  logic                     e_ready,
    output dcache_pkg::load_result_t result,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [7:0]               paddr,
    input  logic [31:0]              pwdata,
    output logic [31:0]              prdata,
    output logic                     pready,
    output logic                     pslverr
);
    import dcache_pkg::*;

    // cache request and response channel
    logic  req_valid;
    logic  req_ready;
    addr_t req_addr;
    logic  rsp_valid;
    logic  rsp_ready;
    data_t rsp_data;

    cfg_t  cfg;
    stat_t stat;

    dcache_load_ctrl load_ctrl0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .a_valid   (a_valid),
        .load_op   (load_op),
        .a_ready   (a_ready),
        .e_valid   (e_valid),
        .e_ready   (e_ready),
        .result    (result),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_addr  (req_addr),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_data  (rsp_data)
    );

    dcache_store store0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .cfg       (cfg),
        .stat      (stat),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_addr  (req_addr),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_data  (rsp_data)
    );

    dcache_cfg_regs cfg_regs0 (
        .clk     (clk),
        .arst_n  (arst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .cfg     (cfg),
        .stat    (stat)
    );

endmodule

// File: tb/dcache_assert.sv
/*
 * dcache_top protocol checks
 * handshake stability on both load channels and APB ready
 */
`timescale 1ns/100ps

module dcache_assert (
    input logic                     clk,
    input logic                     arst_n,
    input logic                     a_valid,
    input logic                     a_ready,
    input dcache_pkg::load_op_t     load_op,
    input logic                     e_valid,
    input logic                     e_ready,
    input dcache_pkg::load_result_t result,
    input logic                     pready
);

    // upstream payload holds while the bundle waits
    property load_op_held;
        @(posedge clk) disable iff (!arst_n)
            a_valid && !a_ready |=> $stable(load_op);
    endproperty

    // result holds and e_valid stays up until taken
    property result_held;
        @(posedge clk) disable iff (!arst_n)
            e_valid && !e_ready |=> e_valid && $stable(result);
    endproperty

    property no_accept_while_done;
        @(posedge clk) disable iff (!arst_n)
            !(a_ready && e_valid);
    endproperty

    property apb_no_wait;
        @(posedge clk) disable iff (!arst_n)
            pready;
    endproperty

    assert property (load_op_held) else $error("load_op changed while a_valid waited");
    assert property (result_held) else $error("result or e_valid changed before e_ready");
    assert property (no_accept_while_done) else $error("a_ready and e_valid high together");
    assert property (apb_no_wait) else $error("pready went low");

endmodule

bind dcache_top dcache_assert assert0 (
    .clk     (clk),
    .arst_n  (arst_n),
    .a_valid (a_valid),
    .a_ready (a_ready),
    .load_op (load_op),
    .e_valid (e_valid),
    .e_ready (e_ready),
    .result  (result),
    .pready  (pready)
);

// File: tb/dcache_tb.sv
/*
 * dcache load side testbench
 * table-driven loads through dcache_top against a reference tag model,
 * APB configuration and random e_ready back-pressure
 */
`timescale 1ns/100ps

module dcache_tb;
    import dcache_pkg::*;

    localparam int NUM_ENTRIES = 14;
    localparam int MAX_WAIT    = 100;

    // one table row with bundle and cache setting
    typedef struct packed {
        addr_t op0_addr;
        logic  op0_valid;
        addr_t op1_addr;
        logic  op1_valid;
        logic  enable;
        logic  flush;
    } entry_t;

    logic                 clk;
    logic                 arst_n;
    logic                 a_valid;
    logic                 a_ready;
    load_op_t             load_op;
    logic                 e_valid;
    logic                 e_ready;
    load_result_t         result;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [7:0]           paddr;
    logic [31:0]          pwdata;
    logic [31:0]          prdata;
    logic                 pready;
    logic                 pslverr;

    data_t                mem_words [MEM_WORDS];
    entry_t               table_q [NUM_ENTRIES];
    logic [NUM_LINES-1:0] ref_valid;
    cache_tag_t           ref_tag [NUM_LINES];
    logic                 cur_enable;
    count_t               exp_hits;
    count_t               exp_misses;
    logic [31:0]          lfsr;
    logic [31:0]          rdata;
    logic                 err;

    dcache_top dut0 (
        .clk     (clk),
        .arst_n  (arst_n),
        .a_valid (a_valid),
        .a_ready (a_ready),
        .load_op (load_op),
        .e_valid (e_valid),
        .e_ready (e_ready),
        .result  (result),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #50 clk = ~clk;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_equal(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("FAIL %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output int unsigned val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            val  = (val << 1) | lfsr[0];
        end
    endtask

    function automatic entry_t make_entry(input addr_t a0, input logic v0, input addr_t a1,
                                          input logic v1, input logic en, input logic fl);
        return '{op0_addr: a0, op0_valid: v0, op1_addr: a1, op1_valid: v1,
                 enable: en, flush: fl};
    endfunction

    function automatic load_op_t to_bundle(input entry_t ent);
        load_op_t op;
        op.op0_addr  = ent.op0_addr;
        op.op0_valid = ent.op0_valid;
        op.op1_addr  = ent.op1_addr;
        op.op1_valid = ent.op1_valid;
        return op;
    endfunction

    // setup and access phase with sampling after the access edge
    task automatic apb_access(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] data,
                              output logic slverr);
        int waited;
        waited = 0;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        while (!pready) begin
            if (waited == MAX_WAIT) begin
                stop_run("timeout waiting for pready on the APB bus");
            end else begin
                @(negedge clk);
                waited++;
            end
        end
        data    = prdata;
        slverr  = pslverr;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata);
        logic [31:0] unused;
        logic        slverr;
        apb_access(1'b1, addr, wdata, unused, slverr);
        check_equal("pslverr", slverr, 1'b0);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        logic slverr;
        apb_access(1'b0, addr, '0, data, slverr);
        check_equal("pslverr", slverr, 1'b0);
    endtask

    // reference tag model predicting hit or miss and the returned word
    task automatic model_access(input addr_t addr, output data_t data);
        cache_index_t idx;
        cache_tag_t   tag;
        idx = addr[4:3];
        tag = addr[6:5];
        if (cur_enable && ref_valid[idx] && ref_tag[idx] == tag) begin
            exp_hits++;
        end else begin
            exp_misses++;
            if (cur_enable) begin
                ref_valid[idx] = 1'b1;
                ref_tag[idx]   = tag;
            end
        end
        data = mem_words[addr[6:3]];
    endtask

    task automatic run_entry(input int k);
        entry_t       ent;
        load_result_t exp;
        int unsigned  lat;
        int unsigned  stall;
        int           waited;
        ent = table_q[k];
        if (ent.enable != cur_enable || ent.flush) begin
            apb_write(REG_CTRL, {30'b0, ent.flush, ent.enable});
            cur_enable = ent.enable;
            if (ent.flush) begin
                ref_valid = '0;
            end
        end
        take_bits(3, lat);
        apb_write(REG_MISS_LAT, lat);

        // operands are fetched in order and skipped ones stay zero
        exp = '0;
        if (ent.op0_valid) begin
            model_access(ent.op0_addr, exp.op0_data);
        end
        if (ent.op1_valid) begin
            model_access(ent.op1_addr, exp.op1_data);
        end

        @(negedge clk);
        a_valid = 1'b1;
        load_op = to_bundle(ent);
        waited  = 0;
        @(posedge clk);
        while (!a_ready) begin
            if (waited == MAX_WAIT) begin
                stop_run("timeout waiting for a_ready to accept the bundle");
            end else begin
                @(posedge clk);
                waited++;
            end
        end
        @(negedge clk);
        a_valid = 1'b0;
        waited  = 0;
        while (!e_valid) begin
            if (waited == MAX_WAIT) begin
                stop_run("timeout waiting for e_valid after the bundle was accepted");
            end else begin
                @(negedge clk);
                waited++;
            end
        end
        check_equal("result", result, exp);

        // stall the result and offer the next bundle meanwhile
        take_bits(3, stall);
        if (k + 1 < NUM_ENTRIES && stall != 0) begin
            a_valid = 1'b1;
            load_op = to_bundle(table_q[k + 1]);
        end
        for (int i = 0; i < stall; i++) begin
            @(negedge clk);
            check_equal("a_ready", a_ready, 1'b0);
            check_equal("e_valid", e_valid, 1'b1);
            check_equal("result", result, exp);
        end
        a_valid = 1'b0;
        e_ready = 1'b1;
        @(negedge clk);
        e_ready = 1'b0;
        check_equal("e_valid", e_valid, 1'b0);

        apb_read(REG_HIT_CNT, rdata);
        check_equal("hit_cnt", rdata, exp_hits);
        apb_read(REG_MISS_CNT, rdata);
        check_equal("miss_cnt", rdata, exp_misses);
    endtask

    task automatic fill_table();
        table_q[0]  = make_entry(32'h008, 1'b1, 32'h000, 1'b0, 1'b1, 1'b0);
        table_q[1]  = make_entry(32'h000, 1'b0, 32'h030, 1'b1, 1'b1, 1'b0);
        table_q[2]  = make_entry(32'h008, 1'b1, 32'h030, 1'b1, 1'b1, 1'b0);
        table_q[3]  = make_entry(32'h048, 1'b1, 32'h008, 1'b1, 1'b1, 1'b0);
        table_q[4]  = make_entry(32'h010, 1'b1, 32'h010, 1'b1, 1'b1, 1'b0);
        table_q[5]  = make_entry(32'h078, 1'b1, 32'h100, 1'b1, 1'b1, 1'b0);
        // upper address bits alias onto the same words
        table_q[6]  = make_entry(32'h178, 1'b1, 32'h000, 1'b1, 1'b1, 1'b0);
        table_q[7]  = make_entry(32'h010, 1'b1, 32'h010, 1'b1, 1'b0, 1'b0);
        table_q[8]  = make_entry(32'h000, 1'b0, 32'h030, 1'b1, 1'b0, 1'b0);
        table_q[9]  = make_entry(32'h010, 1'b1, 32'h030, 1'b1, 1'b1, 1'b0);
        table_q[10] = make_entry(32'h008, 1'b1, 32'h078, 1'b1, 1'b1, 1'b1);
        table_q[11] = make_entry(32'h008, 1'b1, 32'h078, 1'b1, 1'b1, 1'b0);
        table_q[12] = make_entry(32'h058, 1'b1, 32'h000, 1'b0, 1'b1, 1'b0);
        table_q[13] = make_entry(32'h7f8, 1'b1, 32'h020, 1'b1, 1'b1, 1'b0);
    endtask

    initial begin
        clk        = 1'b0;
        arst_n     = 1'b0;
        a_valid    = 1'b0;
        load_op    = '0;
        e_ready    = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        lfsr       = 32'hbc60_4ea2;
        cur_enable = 1'b0;
        ref_valid  = '0;
        exp_hits   = '0;
        exp_misses = '0;
        $readmemh(MEM_INIT_FILE, mem_words);
        fill_table();

        repeat (10) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        // reset state
        check_equal("a_ready", a_ready, 1'b0);
        check_equal("e_valid", e_valid, 1'b0);
        apb_read(REG_CTRL, rdata);
        check_equal("ctrl", rdata, 32'h0);
        apb_read(REG_MISS_LAT, rdata);
        check_equal("miss_lat", rdata, 32'h0);
        apb_read(REG_HIT_CNT, rdata);
        check_equal("hit_cnt", rdata, 32'h0);
        apb_read(REG_MISS_CNT, rdata);
        check_equal("miss_cnt", rdata, 32'h0);
        apb_access(1'b0, 8'h10, '0, rdata, err);
        check_equal("pslverr", err, 1'b1);

        for (int k = 0; k < NUM_ENTRIES; k++) begin
            run_entry(k);
        end

        // any write clears a counter
        apb_write(REG_HIT_CNT, 32'h0000_5a5a);
        apb_write(REG_MISS_CNT, 32'hffff_ffff);
        apb_read(REG_HIT_CNT, rdata);
        check_equal("hit_cnt", rdata, 32'h0);
        apb_read(REG_MISS_CNT, rdata);
        check_equal("miss_cnt", rdata, 32'h0);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: mem_init.hex
// backing store, one 64-bit word per line, word 0 first (address bits 6..3)
0f1e2d3c4b5a6978
a5a5000111c3c30e
3c3c00025a5a1d2b
96e1000378870c4f
c0de0004beef0a51
5eed00051234fa6c
d00d0006abcd87e3
7b7b00070a0b0c0d
e1e1000899aa55c2
4242000913579bdf
b0b0000a2468ace0
19191b0b70f0e1d2
cafe000cf00dba5e
600d000d31415926
feed000e27182818
1dea000f0badc0de

// File: compile.f
source/dcache_pkg.sv
source/dcache_load_ctrl.sv
source/dcache_store.sv
source/dcache_cfg_regs.sv
source/dcache_top.sv
tb/dcache_assert.sv
tb/dcache_tb.sv

// File: Bender.yml
package:
  name: dcache

sources:
  # design, package first
  - files:
      - source/dcache_pkg.sv
      - source/dcache_load_ctrl.sv
      - source/dcache_store.sv
      - source/dcache_cfg_regs.sv
      - source/dcache_top.sv

  # simulation only, top module dcache_tb
  - target: test
    files:
      - tb/dcache_assert.sv
      - tb/dcache_tb.sv
